/* msx_slots.f */
source/msx_slots_pkg.sv
source/slot_select.sv
source/konami_banks.sv
source/ram_segments.sv
source/mem_route.sv
source/msx_slots.sv
dv/msx_slots_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the msx_slots testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module msx_slots_tb -f msx_slots.f -o msx_slots_sim

# a failing check ends in $fatal, which gives a nonzero exit status
./obj_dir/msx_slots_sim

/* dv/msx_slots_tb.sv */
`timescale 1ns/1ps

module msx_slots_tb;
   import msx_slots_pkg::*;

   // bus cycle of one stimulus row
   typedef enum logic [2:0] {
      acc_idle,
      acc_mem_rd,
      acc_mem_wr,
      acc_io_rd,
      acc_io_wr
   } access_t;

   // source of the expected cpu read data
   typedef enum logic [1:0] {
      din_none,
      din_ram,
      din_fixed
   } din_src_t;

   typedef struct packed {
      access_t    kind;
      cpu_addr_t  addr;
      data_t      data;
      logic [1:0] slot;
      data_t      ram_data;
      logic       addr_chk;
      ram_addr_t  exp_addr;
      logic       exp_ce;
      din_src_t   din_src;
      data_t      exp_din;
   } row_t;

   logic                     clk;
   logic                     reset;
   cpu_bus_t                 bus;
   logic [1:0]               active_slot;
   logic [3:0]               slot_expander_en;
   block_t      [63:0]       slot_layout;
   ram_region_t [15:0]       lookup_ram;
   data_t                    ram_dout;
   ram_addr_t                ram_addr;
   data_t                    ram_din;
   logic                     ram_rnw;
   logic                     ram_ce;
   data_t                    cpu_din;

   row_t        stim[$];
   logic [31:0] rnd_state;

   msx_slots i_msx_slots (
      .clk              (clk),
      .reset            (reset),
      .bus              (bus),
      .active_slot      (active_slot),
      .slot_expander_en (slot_expander_en),
      .slot_layout      (slot_layout),
      .lookup_ram       (lookup_ram),
      .ram_dout         (ram_dout),
      .ram_addr         (ram_addr),
      .ram_din          (ram_din),
      .ram_rnw          (ram_rnw),
      .ram_ce           (ram_ce),
      .cpu_din          (cpu_din)
   );

   // 4 ns period
   always #2 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic block_t make_block(input logic [3:0] ref_ram, input logic [1:0] offset_ram,
                                         input logic cart_num, input mapper_t mapper);
      block_t b;
      b.ref_ram    = ref_ram;
      b.offset_ram = offset_ram;
      b.cart_num   = cart_num;
      b.mapper     = mapper;
      return b;
   endfunction

   function automatic ram_region_t make_region(input ram_addr_t base, input logic [15:0] size,
                                               input logic ro);
      ram_region_t r;
      r.base = base;
      r.size = size;
      r.ro   = ro;
      return r;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("[FAIL] time %0t %s got %h expected %h", $time, name, got, exp);
         $display("TESTBENCH FAILED");
         $fatal(1, "output mismatch");
      end
   endtask

   // layout index is slot*16 + subslot*4 + page
   task automatic load_layout();
      for (int i = 0; i < 64; i++) begin
         slot_layout[6'(i)] = make_block(4'd0, 2'd0, 1'b0, mapper_unused);
      end
      for (int i = 0; i < 16; i++) begin
         lookup_ram[4'(i)] = make_region(27'h0, 16'd0, 1'b0);
      end
      for (int p = 0; p < 4; p++) begin
         // slot 0 subslot 0 plain rom with pages stored in reverse
         slot_layout[6'(p)]      = make_block(4'd0, 2'(3 - p), 1'b0, mapper_none);
         // slot 0 subslot 1, msx2 ram
         slot_layout[6'(4 + p)]  = make_block(4'd1, 2'd0, 1'b0, mapper_ram);
         slot_layout[6'(16 + p)] = make_block(4'd2, 2'd0, 1'b0, mapper_linear);
         slot_layout[6'(32 + p)] = make_block(4'd3, 2'd0, 1'b0, mapper_konami);
      end
      // slot 3 offset rom on pages 0 to 2
      for (int p = 0; p < 3; p++) begin
         slot_layout[6'(48 + p)] = make_block(4'd4, 2'd0, 1'b0, mapper_offset);
      end
      // slot 3 page 3 unused but still in region 4
      slot_layout[6'(51)] = make_block(4'd4, 2'd0, 1'b0, mapper_unused);
      lookup_ram[0] = make_region(27'h0010000, 16'd4, 1'b0);
      // 8 segments
      lookup_ram[1] = make_region(27'h0100000, 16'd8, 1'b0);
      // 32 KB mirrored
      lookup_ram[2] = make_region(27'h0200000, 16'd2, 1'b0);
      lookup_ram[3] = make_region(27'h0300000, 16'd8, 1'b0);
      lookup_ram[4] = make_region(27'h0400000, 16'd4, 1'b1);
   endtask

   task automatic add_row(input access_t kind, input cpu_addr_t addr, input data_t data,
                          input logic [1:0] slot, input logic addr_chk, input ram_addr_t exp_addr,
                          input logic exp_ce, input din_src_t din_src, input data_t exp_din);
      row_t r;
      rnd_state  = xorshift32(rnd_state);
      r.kind     = kind;
      r.addr     = addr;
      r.data     = data;
      r.slot     = slot;
      r.ram_data = rnd_state[7:0];
      r.addr_chk = addr_chk;
      r.exp_addr = exp_addr;
      r.exp_ce   = exp_ce;
      r.din_src  = din_src;
      r.exp_din  = exp_din;
      stim.push_back(r);
   endtask

   task automatic build_stimulus();
      // none mapper gives base 10000 + addr[13:0] + (3 - page) * 4000
      add_row(acc_idle,   16'h0000, 8'h00, 2'd0, 1'b0, 27'h0,       1'b0, din_none,  8'h00);
      add_row(acc_mem_rd, 16'h1234, 8'h00, 2'd0, 1'b1, 27'h001D234, 1'b1, din_ram,   8'h00);
      add_row(acc_mem_rd, 16'h8ABC, 8'h00, 2'd0, 1'b1, 27'h0014ABC, 1'b1, din_ram,   8'h00);
      add_row(acc_mem_wr, 16'h4567, 8'h5A, 2'd0, 1'b1, 27'h0018567, 1'b1, din_none,  8'h00);
      // linear mask 7FFF wraps the upper half
      add_row(acc_mem_rd, 16'h2345, 8'h00, 2'd1, 1'b1, 27'h0202345, 1'b1, din_ram,   8'h00);
      add_row(acc_mem_rd, 16'h9345, 8'h00, 2'd1, 1'b1, 27'h0201345, 1'b1, din_ram,   8'h00);
      add_row(acc_mem_rd, 16'hFEDC, 8'h00, 2'd1, 1'b1, 27'h0207EDC, 1'b1, din_ram,   8'h00);
      // 04 puts page 1 of slot 0 in subslot 1
      add_row(acc_mem_wr, 16'hFFFF, 8'h04, 2'd0, 1'b1, 27'h0013FFF, 1'b1, din_none,  8'h00);
      // reset segment of page 1 is 2
      add_row(acc_mem_rd, 16'h4100, 8'h00, 2'd0, 1'b1, 27'h0108100, 1'b1, din_ram,   8'h00);
      add_row(acc_mem_rd, 16'hFFFF, 8'h00, 2'd0, 1'b1, 27'h0013FFF, 1'b1, din_fixed, 8'hFB);
      add_row(acc_mem_rd, 16'h0100, 8'h00, 2'd0, 1'b1, 27'h001C100, 1'b1, din_ram,   8'h00);
      // slot 3 not expanded so its subslot stays 0
      add_row(acc_mem_wr, 16'hFFFF, 8'h55, 2'd3, 1'b1, 27'h040DEAD, 1'b0, din_none,  8'h00);
      add_row(acc_mem_rd, 16'h4000, 8'h00, 2'd3, 1'b1, 27'h0400000, 1'b1, din_ram,   8'h00);
      // segment 5 for page 1
      add_row(acc_io_wr,  16'h00FD, 8'h05, 2'd0, 1'b0, 27'h0,       1'b0, din_none,  8'h00);
      add_row(acc_mem_rd, 16'h4ABC, 8'h00, 2'd0, 1'b1, 27'h0114ABC, 1'b1, din_ram,   8'h00);
      add_row(acc_mem_wr, 16'h7FFF, 8'h3C, 2'd0, 1'b1, 27'h0117FFF, 1'b1, din_none,  8'h00);
      // segment 0B masked to 3
      add_row(acc_io_wr,  16'h00FD, 8'h0B, 2'd0, 1'b0, 27'h0,       1'b0, din_none,  8'h00);
      add_row(acc_mem_rd, 16'h4010, 8'h00, 2'd0, 1'b1, 27'h010C010, 1'b1, din_ram,   8'h00);
      add_row(acc_io_rd,  16'h00FD, 8'h00, 2'd0, 1'b0, 27'h0,       1'b0, din_fixed, 8'h0B);
      // konami reset banks 0..3 under mask 1FFFF
      add_row(acc_mem_rd, 16'h4123, 8'h00, 2'd2, 1'b1, 27'h0300123, 1'b1, din_ram,   8'h00);
      add_row(acc_mem_rd, 16'h6123, 8'h00, 2'd2, 1'b1, 27'h0302123, 1'b1, din_ram,   8'h00);
      add_row(acc_mem_rd, 16'h8123, 8'h00, 2'd2, 1'b1, 27'h0304123, 1'b1, din_ram,   8'h00);
      add_row(acc_mem_rd, 16'hA123, 8'h00, 2'd2, 1'b1, 27'h0306123, 1'b1, din_ram,   8'h00);
      // bank 2 becomes 0D
      add_row(acc_mem_wr, 16'h8000, 8'h0D, 2'd2, 1'b1, 27'h0304000, 1'b1, din_none,  8'h00);
      add_row(acc_mem_rd, 16'h8123, 8'h00, 2'd2, 1'b1, 27'h031A123, 1'b1, din_ram,   8'h00);
      add_row(acc_mem_rd, 16'h9FFF, 8'h00, 2'd2, 1'b1, 27'h031BFFF, 1'b1, din_ram,   8'h00);
      add_row(acc_mem_rd, 16'h6123, 8'h00, 2'd2, 1'b1, 27'h0302123, 1'b1, din_ram,   8'h00);
      // bank 12 past the rom size wraps to 2
      add_row(acc_mem_wr, 16'hA000, 8'h12, 2'd2, 1'b1, 27'h0306000, 1'b1, din_none,  8'h00);
      add_row(acc_mem_rd, 16'hA010, 8'h00, 2'd2, 1'b1, 27'h0304010, 1'b1, din_ram,   8'h00);
      add_row(acc_mem_rd, 16'h0000, 8'h00, 2'd2, 1'b1, 27'h030DEAD, 1'b1, din_fixed, 8'hFF);
      // offset mapper on a read only region
      add_row(acc_mem_rd, 16'h5678, 8'h00, 2'd3, 1'b1, 27'h0401678, 1'b1, din_ram,   8'h00);
      add_row(acc_mem_rd, 16'hBFFF, 8'h00, 2'd3, 1'b1, 27'h0407FFF, 1'b1, din_ram,   8'h00);
      add_row(acc_mem_wr, 16'h4800, 8'h77, 2'd3, 1'b1, 27'h0400800, 1'b0, din_none,  8'h00);
      add_row(acc_mem_rd, 16'hC000, 8'h00, 2'd3, 1'b1, 27'h040DEAD, 1'b0, din_fixed, 8'hFF);
      add_row(acc_idle,   16'h0000, 8'h00, 2'd0, 1'b0, 27'h0,       1'b0, din_none,  8'h00);
   endtask

   task automatic drive_row(input row_t r);
      cpu_bus_t b;
      b      = '0;
      b.addr = r.addr;
      b.dout = r.data;
      case (r.kind)
         acc_mem_rd: begin
            b.mreq = 1'b1;
            b.rd   = 1'b1;
         end
         acc_mem_wr: begin
            b.mreq = 1'b1;
            b.wr   = 1'b1;
         end
         acc_io_rd: begin
            b.iorq = 1'b1;
            b.rd   = 1'b1;
         end
         acc_io_wr: begin
            b.iorq = 1'b1;
            b.wr   = 1'b1;
         end
         default: begin
         end
      endcase
      bus         = b;
      active_slot = r.slot;
      ram_dout    = r.ram_data;
   endtask

   task automatic check_row(input row_t r, input int idx);
      logic exp_rnw;
      exp_rnw = (r.kind == acc_mem_rd) || (r.kind == acc_io_rd);
      check_value($sformatf("row %0d ram_ce", idx), 32'(ram_ce), 32'(r.exp_ce));
      check_value($sformatf("row %0d ram_rnw", idx), 32'(ram_rnw), 32'(exp_rnw));
      check_value($sformatf("row %0d ram_din", idx), 32'(ram_din), 32'(r.data));
      if (r.addr_chk) begin
         check_value($sformatf("row %0d ram_addr", idx), 32'(ram_addr), 32'(r.exp_addr));
      end
      if (r.din_src == din_ram) begin
         check_value($sformatf("row %0d cpu_din", idx), 32'(cpu_din), 32'(r.ram_data));
      end else if (r.din_src == din_fixed) begin
         check_value($sformatf("row %0d cpu_din", idx), 32'(cpu_din), 32'(r.exp_din));
      end
   endtask

   // idle bus must drop the ram strobe
   task automatic wait_ram_idle(input int max_cycles);
      int n;
      n = 0;
      while (ram_ce !== 1'b0 && n < max_cycles) begin
         @(negedge clk);
         n++;
      end
      if (ram_ce !== 1'b0) begin
         $display("ram_ce stayed active on an idle bus after reset");
         $display("TESTBENCH FAILED");
         $fatal(1, "timeout waiting for an idle ram strobe");
      end
   endtask

   initial begin
      clk              = 1'b0;
      reset            = 1'b1;
      bus              = '0;
      active_slot      = 2'd0;
      // only slot 0 is expanded
      slot_expander_en = 4'b0001;
      ram_dout         = 8'h00;
      rnd_state        = 32'd53;
      load_layout();
      build_stimulus();

      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      wait_ram_idle(8);

      foreach (stim[i]) begin
         @(negedge clk);
         drive_row(stim[i]);
         // outputs settle well before the next rising edge
         #1;
         check_row(stim[i], i);
      end

      @(negedge clk);
      bus = '0;
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

/* source/msx_slots.sv */
`timescale 1ns/1ps

module msx_slots (
   input  logic                              clk,
   input  logic                              reset,
   input  msx_slots_pkg::cpu_bus_t           bus,
   input  logic [1:0]                        active_slot,
   input  logic [3:0]                        slot_expander_en,
   input  msx_slots_pkg::block_t      [63:0] slot_layout,
   input  msx_slots_pkg::ram_region_t [15:0] lookup_ram,
   input  msx_slots_pkg::data_t              ram_dout,
   output msx_slots_pkg::ram_addr_t          ram_addr,
   output msx_slots_pkg::data_t              ram_din,
   output logic                              ram_rnw,
   output logic                              ram_ce,
   output msx_slots_pkg::data_t              cpu_din
);
   import msx_slots_pkg::*;

   slot_sel_t     sel;
   konami_addr_t  konami_addr;
   logic          konami_unmapped;
   segment_addr_t segment_addr;
   logic          segment_req;
   data_t         segment_dout;

   // where the access goes
   slot_select i_slot_select (
      .clk              (clk),
      .reset            (reset),
      .bus              (bus),
      .active_slot      (active_slot),
      .slot_expander_en (slot_expander_en),
      .slot_layout      (slot_layout),
      .lookup_ram       (lookup_ram),
      .sel              (sel)
   );

   // konami rom banks, both cartridges
   konami_banks i_konami_banks (
      .clk             (clk),
      .reset           (reset),
      .bus             (bus),
      .sel             (sel),
      .konami_addr     (konami_addr),
      .konami_unmapped (konami_unmapped)
   );

   // msx2 ram segments on FC..FF
   ram_segments i_ram_segments (
      .clk          (clk),
      .reset        (reset),
      .bus          (bus),
      .sel          (sel),
      .segment_addr (segment_addr),
      .segment_req  (segment_req),
      .segment_dout (segment_dout)
   );

   // ram address, strobes and cpu read data
   mem_route i_mem_route (
      .bus             (bus),
      .sel             (sel),
      .konami_addr     (konami_addr),
      .konami_unmapped (konami_unmapped),
      .segment_addr    (segment_addr),
      .segment_req     (segment_req),
      .segment_dout    (segment_dout),
      .ram_dout        (ram_dout),
      .ram_addr        (ram_addr),
      .ram_din         (ram_din),
      .ram_rnw         (ram_rnw),
      .ram_ce          (ram_ce),
      .cpu_din         (cpu_din)
   );

endmodule

/* source/mem_route.sv */
`timescale 1ns/1ps

module mem_route (
   input  msx_slots_pkg::cpu_bus_t   bus,
   input  msx_slots_pkg::slot_sel_t  sel,
   input  logic [24:0]               konami_addr,
   input  logic                      konami_unmapped,
   input  logic [21:0]               segment_addr,
   input  logic                      segment_req,
   input  msx_slots_pkg::data_t      segment_dout,
   input  msx_slots_pkg::data_t      ram_dout,
   output msx_slots_pkg::ram_addr_t  ram_addr,
   output msx_slots_pkg::data_t      ram_din,
   output logic                      ram_rnw,
   output logic                      ram_ce,
   output msx_slots_pkg::data_t      cpu_din
);
   import msx_slots_pkg::*;

   ram_addr_t none_addr;
   ram_addr_t linear_addr;
   ram_addr_t offset_addr;
   ram_addr_t size_mask;
   ram_addr_t mapper_addr;
   logic      unused_sel;

   // plain rom, page picked by offset_ram
   assign none_addr = ram_addr_t'(bus.addr[page_bits-1:0]) +
                      (ram_addr_t'(sel.offset_ram) << page_bits);

   // region size in bytes minus one
   assign size_mask = (ram_addr_t'(sel.region.size) << page_bits) - ram_addr_t'(1);

   // linear rom mirrors under the size mask
   assign linear_addr = ram_addr_t'(bus.addr) & size_mask;

   // rom starting at 4000
   assign offset_addr = ram_addr_t'(bus.addr) - ram_addr_t'(offset_base);

   always_comb begin
      if (konami_unmapped) begin
         mapper_addr = unmapped_addr;
      end else begin
         unique case (sel.mapper)
            mapper_none:   mapper_addr = none_addr;
            mapper_linear: mapper_addr = linear_addr;
            mapper_offset: mapper_addr = offset_addr;
            mapper_konami: mapper_addr = ram_addr_t'(konami_addr);
            mapper_ram:    mapper_addr = ram_addr_t'(segment_addr);
            default:       mapper_addr = unmapped_addr;
         endcase
      end
   end

   // region base first, mapper offset on top
   assign ram_addr = sel.region.base + mapper_addr;

   assign unused_sel = (sel.mapper == mapper_unused);

   // writes to a read only region never reach the ram
   assign ram_ce  = bus.mreq && (bus.rd || (bus.wr && !sel.region.ro)) && !unused_sel;
   assign ram_rnw = bus.rd;
   assign ram_din = bus.dout;

   // read data, first match wins
   always_comb begin
      if (segment_req) begin
         cpu_din = segment_dout;
      end else if (sel.expander_rd) begin
         cpu_din = sel.expander_val;
      end else if (unused_sel || konami_unmapped) begin
         cpu_din = open_bus;
      end else begin
         cpu_din = ram_dout;
      end
   end

endmodule

/* source/ram_segments.sv */
`timescale 1ns/1ps

module ram_segments (
   input  logic                      clk,
   input  logic                      reset,
   input  msx_slots_pkg::cpu_bus_t   bus,
   input  msx_slots_pkg::slot_sel_t  sel,
   output logic [21:0]               segment_addr,
   output logic                      segment_req,
   output msx_slots_pkg::data_t      segment_dout
);
   import msx_slots_pkg::*;

   // one segment per 16 KB page
   bank_t [3:0] segments;

   logic  port_hit;
   logic  io_cycle;
   bank_t seg_mask;
   bank_t segment;

   // ports FC..FF, the low two bits pick the page
   assign port_hit = (bus.addr[7:2] == segment_port_base[7:2]);

   // m1 with iorq is an interrupt ack, not a port access
   assign io_cycle = bus.iorq && !bus.m1 && port_hit;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         // page 0 gets the top segment
         for (int p = 0; p < 4; p++) begin
            segments[p] <= bank_t'(3 - p);
         end
      end else if (io_cycle && bus.wr) begin
         segments[bus.addr[1:0]] <= bus.dout;
      end
   end

   // segment count is a power of two
   assign seg_mask = sel.region.size[7:0] - bank_t'(1);

   // segment of the page being accessed
   assign segment = segments[bus.addr[15:page_bits]] & seg_mask;

   assign segment_addr = {segment, bus.addr[page_bits-1:0]};

   // port read back
   assign segment_req  = io_cycle && bus.rd;
   assign segment_dout = segment_req ? segments[bus.addr[1:0]] : open_bus;

endmodule

/* source/konami_banks.sv */
`timescale 1ns/1ps

module konami_banks (
   input  logic                      clk,
   input  logic                      reset,
   input  msx_slots_pkg::cpu_bus_t   bus,
   input  msx_slots_pkg::slot_sel_t  sel,
   output logic [24:0]               konami_addr,
   output logic                      konami_unmapped
);
   import msx_slots_pkg::*;

   // four 8 KB windows per cartridge
   bank_t [1:0][3:0] banks;

   logic         konami_sel;
   logic         bank_wr;
   logic [1:0]   window;
   bank_t        bank;
   konami_addr_t size_mask;

   assign konami_sel = (sel.mapper == mapper_konami);

   // 4000 -> 0, 6000 -> 1, 8000 -> 2, A000 -> 3
   assign window = {~bus.addr[14], bus.addr[13]};

   // bank registers sit at 6000..BFFF, window 0 has none
   assign bank_wr = konami_sel && bus.mreq && bus.wr &&
                    (bus.addr >= 16'h6000) && (bus.addr < 16'hC000);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int c = 0; c < 2; c++) begin
            for (int b = 0; b < 4; b++) begin
               banks[c][b] <= bank_t'(b);
            end
         end
      end else if (bank_wr) begin
         banks[sel.cart_num][window] <= bus.dout;
      end
   end

   assign bank = banks[sel.cart_num][window];

   // rom size in bytes minus one
   assign size_mask = (konami_addr_t'(sel.region.size) << page_bits) - konami_addr_t'(1);

   assign konami_addr = (konami_addr_t'(bank) << konami_bank_bits |
                         konami_addr_t'(bus.addr[konami_bank_bits-1:0])) & size_mask;

   // only pages 1 and 2 carry rom
   assign konami_unmapped = konami_sel &&
                            ((bus.addr[15:14] == 2'b00) || (bus.addr[15:14] == 2'b11));

endmodule

/* source/slot_select.sv */
`timescale 1ns/1ps

module slot_select (
   input  logic                              clk,
   input  logic                              reset,
   input  msx_slots_pkg::cpu_bus_t           bus,
   input  logic [1:0]                        active_slot,
   input  logic [3:0]                        slot_expander_en,
   input  msx_slots_pkg::block_t      [63:0] slot_layout,
   input  msx_slots_pkg::ram_region_t [15:0] lookup_ram,
   output msx_slots_pkg::slot_sel_t          sel
);
   import msx_slots_pkg::*;

   // one subslot register per primary slot
   data_t [3:0] subslot_reg;

   logic       expander_hit;
   logic       expander_wr;
   logic [1:0] page;
   logic [1:0] subslot;
   logic [5:0] layout_id;
   block_t     blk;

   // 16 KB page of the access
   assign page = bus.addr[15:page_bits];

   // FFFF only acts as a register in an expanded slot
   assign expander_hit = (bus.addr == expander_addr) && slot_expander_en[active_slot];
   assign expander_wr  = expander_hit && bus.mreq && bus.wr;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         subslot_reg <= '0;
      end else if (expander_wr) begin
         subslot_reg[active_slot] <= bus.dout;
      end
   end

   // two bits per page, page 0 in bits 1:0
   assign subslot = subslot_reg[active_slot][{page, 1'b0} +: 2];

   // slot, subslot, page
   assign layout_id = {active_slot, subslot, page};
   assign blk       = slot_layout[layout_id];

   always_comb begin
      sel.mapper     = blk.mapper;
      sel.cart_num   = blk.cart_num;
      sel.offset_ram = blk.offset_ram;
      // second lookup, region of the block
      sel.region     = lookup_ram[blk.ref_ram];
      // the register reads back inverted
      sel.expander_rd  = expander_hit && bus.mreq && bus.rd;
      sel.expander_val = ~subslot_reg[active_slot];
   end

endmodule

/* source/msx_slots_pkg.sv */
package msx_slots_pkg;

   // cpu side widths
   typedef logic [15:0] cpu_addr_t;
   typedef logic [7:0]  data_t;

   // external ram address, 128 MB space
   typedef logic [26:0] ram_addr_t;

   // bank number for konami, segment number for the msx2 mapper
   typedef logic [7:0]  bank_t;

   // mapper outputs before the region base is added
   typedef logic [24:0] konami_addr_t;
   typedef logic [21:0] segment_addr_t;

   // 16 KB page, 8 KB konami bank
   localparam int page_bits        = 14;
   localparam int konami_bank_bits = 13;

   // subslot register lives at the very top of memory
   localparam cpu_addr_t expander_addr = 16'hFFFF;

   // offset mapper shifts page 1 down to zero
   localparam cpu_addr_t offset_base = 16'h4000;

   // filler address for unmapped konami accesses
   localparam ram_addr_t unmapped_addr = 27'hDEAD;

   // value the cpu sees on an empty location
   localparam data_t open_bus = 8'hFF;

   // msx2 mapper ports FC..FF
   localparam data_t segment_port_base = 8'hFC;

   typedef enum logic [2:0] {
      mapper_none,
      mapper_ram,
      mapper_linear,
      mapper_offset,
      mapper_konami,
      mapper_unused
   } mapper_t;

   // plain z80 bus levels
   typedef struct packed {
      cpu_addr_t addr;
      data_t     dout;
      logic      rd;
      logic      wr;
      logic      mreq;
      logic      iorq;
      logic      m1;
   } cpu_bus_t;

   // one entry of the 64 entry layout table
   typedef struct packed {
      logic [3:0] ref_ram;
      logic [1:0] offset_ram;
      logic       cart_num;
      mapper_t    mapper;
   } block_t;

   // one entry of the 16 entry ram region table
   typedef struct packed {
      ram_addr_t   base;
      // size counted in 16 KB pages
      logic [15:0] size;
      logic        ro;
   } ram_region_t;

   // result of the slot lookup for the current access
   typedef struct packed {
      mapper_t     mapper;
      logic        cart_num;
      logic [1:0]  offset_ram;
      ram_region_t region;
      logic        expander_rd;
      data_t       expander_val;
   } slot_sel_t;

endpackage
